// File: verilog/spu_isa_pkg.sv
package spu_isa_pkg;

	// instruction format as presented by the issue stage
	typedef enum logic [2:0] {
		FMT_RR   = 3'd0,
		FMT_RI10 = 3'd4,
		FMT_RI16 = 3'd5
	} fmt_e;

	// raw opcode field, shorter opcodes right-aligned
	typedef logic [10:0] op_field_t;

	// immediate field
	typedef logic [17:0] imm_t;
	localparam int IMM10_BITS = 10;
	localparam int IMM16_BITS = 16;

	// rr opcodes, full 11 bits
	localparam op_field_t OPC_AH    = 11'b00011001000;
	localparam op_field_t OPC_A     = 11'b00011000000;
	localparam op_field_t OPC_SFH   = 11'b00001001000;
	localparam op_field_t OPC_SF    = 11'b00001000000;
	localparam op_field_t OPC_AND   = 11'b00011000001;
	localparam op_field_t OPC_OR    = 11'b00001000001;
	localparam op_field_t OPC_XOR   = 11'b01001000001;
	localparam op_field_t OPC_NAND  = 11'b00011001001;
	localparam op_field_t OPC_CEQH  = 11'b01111001000;
	localparam op_field_t OPC_CEQ   = 11'b01111000000;
	localparam op_field_t OPC_CGTH  = 11'b01001001000;
	localparam op_field_t OPC_CGT   = 11'b01001000000;
	localparam op_field_t OPC_CLGTH = 11'b01011001000;
	localparam op_field_t OPC_CLGT  = 11'b01011000000;

	// ri10 opcodes, 8 bits
	localparam op_field_t OPC_AHI    = {3'b000, 8'b00011101};
	localparam op_field_t OPC_AI     = {3'b000, 8'b00011100};
	localparam op_field_t OPC_SFHI   = {3'b000, 8'b00001101};
	localparam op_field_t OPC_SFI    = {3'b000, 8'b00001100};
	localparam op_field_t OPC_ANDHI  = {3'b000, 8'b00010101};
	localparam op_field_t OPC_ANDI   = {3'b000, 8'b00010100};
	localparam op_field_t OPC_ORHI   = {3'b000, 8'b00000101};
	localparam op_field_t OPC_ORI    = {3'b000, 8'b00000100};
	localparam op_field_t OPC_XORHI  = {3'b000, 8'b01000101};
	localparam op_field_t OPC_XORI   = {3'b000, 8'b01000100};
	localparam op_field_t OPC_CEQHI  = {3'b000, 8'b01111101};
	localparam op_field_t OPC_CEQI   = {3'b000, 8'b01111100};
	localparam op_field_t OPC_CGTHI  = {3'b000, 8'b01001101};
	localparam op_field_t OPC_CGTI   = {3'b000, 8'b01001100};
	localparam op_field_t OPC_CLGTHI = {3'b000, 8'b01011101};
	localparam op_field_t OPC_CLGTI  = {3'b000, 8'b01011100};

	// ri16 opcodes, 9 bits
	localparam op_field_t OPC_ILH  = {2'b00, 9'b010000011};
	localparam op_field_t OPC_ILHU = {2'b00, 9'b010000010};
	localparam op_field_t OPC_IOHL = {2'b00, 9'b011000001};

	// decoded operation
	typedef enum logic [3:0] {
		OP_NOP, OP_ADD, OP_SUBF, OP_AND, OP_OR, OP_XOR, OP_NAND,
		OP_CEQ, OP_CGT, OP_CLGT, OP_ILH, OP_ILHU, OP_IOHL
	} fx_op_e;

	typedef enum logic {SZ_HALF, SZ_WORD} lane_size_e;

endpackage

// File: verilog/spu_data_pkg.sv
package spu_data_pkg;

	// quadword and its lane splits
	localparam int QUAD_WIDTH = 128;
	localparam int HALF_LANES = 8;
	localparam int WORD_LANES = 4;
	localparam int HALF_WIDTH = QUAD_WIDTH / HALF_LANES;
	localparam int WORD_WIDTH = QUAD_WIDTH / WORD_LANES;

	// lane 0 lives in the top bits
	typedef logic [QUAD_WIDTH-1:0] quad_t;
	typedef logic [HALF_WIDTH-1:0] half_t;
	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [6:0] reg_addr_t;

	// one issued instruction with its operands
	typedef struct packed {
		spu_isa_pkg::fmt_e      format;
		spu_isa_pkg::op_field_t op;
		reg_addr_t              rt_addr;
		quad_t                  ra;
		quad_t                  rb;
		quad_t                  rt_st;
		spu_isa_pkg::imm_t      imm;
		logic                   reg_write;
	} fx_issue_t;

	typedef struct packed {
		spu_isa_pkg::fx_op_e     op;
		spu_isa_pkg::lane_size_e size;
		quad_t                   b;
	} fx_decoded_t;

	// writeback to the register file
	typedef struct packed {
		quad_t     result;
		reg_addr_t rt_addr;
		logic      reg_write;
	} fx_wb_t;

endpackage

// File: verilog/fx_decode.sv
`timescale 1ns/1ps

module fx_decode (
	input  spu_isa_pkg::fmt_e        format,
	input  spu_isa_pkg::op_field_t   op,
	input  spu_isa_pkg::imm_t        imm,
	input  spu_data_pkg::quad_t      rb,
	output spu_data_pkg::fx_decoded_t dec
);

	typedef struct packed {
		spu_isa_pkg::fx_op_e     op;
		spu_isa_pkg::lane_size_e size;
	} op_size_t;

	op_size_t sel;
	spu_data_pkg::half_t imm10_half;
	spu_data_pkg::word_t imm10_word;
	logic [spu_isa_pkg::IMM16_BITS-1:0] imm16;

	// sign-extend imm10 to each lane width
	assign imm10_half = {{(spu_data_pkg::HALF_WIDTH - spu_isa_pkg::IMM10_BITS){imm[9]}},
		imm[spu_isa_pkg::IMM10_BITS-1:0]};
	assign imm10_word = {{(spu_data_pkg::WORD_WIDTH - spu_isa_pkg::IMM10_BITS){imm[9]}},
		imm[spu_isa_pkg::IMM10_BITS-1:0]};
	assign imm16 = imm[spu_isa_pkg::IMM16_BITS-1:0];

	// opcode table per format, anything unmatched is a nop
	always_comb begin
		sel = '{spu_isa_pkg::OP_NOP, spu_isa_pkg::SZ_HALF};
		case (format)
			spu_isa_pkg::FMT_RR: begin
				case (op)
					spu_isa_pkg::OPC_AH: sel = '{spu_isa_pkg::OP_ADD, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_A: sel = '{spu_isa_pkg::OP_ADD, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_SFH: sel = '{spu_isa_pkg::OP_SUBF, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_SF: sel = '{spu_isa_pkg::OP_SUBF, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_AND: sel = '{spu_isa_pkg::OP_AND, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_OR: sel = '{spu_isa_pkg::OP_OR, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_XOR: sel = '{spu_isa_pkg::OP_XOR, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_NAND: sel = '{spu_isa_pkg::OP_NAND, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_CEQH: sel = '{spu_isa_pkg::OP_CEQ, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_CEQ: sel = '{spu_isa_pkg::OP_CEQ, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_CGTH: sel = '{spu_isa_pkg::OP_CGT, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_CGT: sel = '{spu_isa_pkg::OP_CGT, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_CLGTH: sel = '{spu_isa_pkg::OP_CLGT, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_CLGT: sel = '{spu_isa_pkg::OP_CLGT, spu_isa_pkg::SZ_WORD};
					default: ;
				endcase
			end
			spu_isa_pkg::FMT_RI10: begin
				case (op)
					spu_isa_pkg::OPC_AHI: sel = '{spu_isa_pkg::OP_ADD, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_AI: sel = '{spu_isa_pkg::OP_ADD, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_SFHI: sel = '{spu_isa_pkg::OP_SUBF, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_SFI: sel = '{spu_isa_pkg::OP_SUBF, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_ANDHI: sel = '{spu_isa_pkg::OP_AND, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_ANDI: sel = '{spu_isa_pkg::OP_AND, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_ORHI: sel = '{spu_isa_pkg::OP_OR, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_ORI: sel = '{spu_isa_pkg::OP_OR, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_XORHI: sel = '{spu_isa_pkg::OP_XOR, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_XORI: sel = '{spu_isa_pkg::OP_XOR, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_CEQHI: sel = '{spu_isa_pkg::OP_CEQ, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_CEQI: sel = '{spu_isa_pkg::OP_CEQ, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_CGTHI: sel = '{spu_isa_pkg::OP_CGT, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_CGTI: sel = '{spu_isa_pkg::OP_CGT, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_CLGTHI: sel = '{spu_isa_pkg::OP_CLGT, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_CLGTI: sel = '{spu_isa_pkg::OP_CLGT, spu_isa_pkg::SZ_WORD};
					default: ;
				endcase
			end
			spu_isa_pkg::FMT_RI16: begin
				case (op)
					spu_isa_pkg::OPC_ILH: sel = '{spu_isa_pkg::OP_ILH, spu_isa_pkg::SZ_HALF};
					spu_isa_pkg::OPC_ILHU: sel = '{spu_isa_pkg::OP_ILHU, spu_isa_pkg::SZ_WORD};
					spu_isa_pkg::OPC_IOHL: sel = '{spu_isa_pkg::OP_IOHL, spu_isa_pkg::SZ_WORD};
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// second operand, rb unless an immediate format
	always_comb begin
		dec.op = sel.op;
		dec.size = sel.size;
		case (format)
			spu_isa_pkg::FMT_RI10: begin
				if (sel.size == spu_isa_pkg::SZ_WORD)
					dec.b = {spu_data_pkg::WORD_LANES{imm10_word}};
				else
					dec.b = {spu_data_pkg::HALF_LANES{imm10_half}};
			end
			spu_isa_pkg::FMT_RI16: begin
				case (sel.op)
					// every halfword gets imm16
					spu_isa_pkg::OP_ILH: dec.b = {spu_data_pkg::HALF_LANES{imm16}};
					spu_isa_pkg::OP_ILHU: dec.b = {spu_data_pkg::WORD_LANES{imm16, 16'h0000}};
					default: dec.b = {spu_data_pkg::WORD_LANES{16'h0000, imm16}};
				endcase
			end
			default: dec.b = rb;
		endcase
	end

	// a clean instruction must never decode to x
	always_comb begin
		if (!$isunknown({format, op}))
			a_dec_known: assert final (!$isunknown(dec.op))
				else $error("fx_decode: unknown operation from a known format and opcode");
	end

endmodule

// File: verilog/fx_arith.sv
`timescale 1ns/1ps

module fx_arith (
	input  spu_isa_pkg::fx_op_e     op,
	input  spu_isa_pkg::lane_size_e size,
	input  spu_data_pkg::quad_t     a,
	input  spu_data_pkg::quad_t     b,
	output spu_data_pkg::quad_t     sum
);

	// index 0 halfword lanes, index 1 word lanes
	logic [1:0][spu_data_pkg::QUAD_WIDTH-1:0] size_sum;

	for (genvar s = 0; s < 2; s++) begin : g_size
		localparam int W = (s == 0) ? spu_data_pkg::HALF_WIDTH : spu_data_pkg::WORD_WIDTH;
		localparam int N = spu_data_pkg::QUAD_WIDTH / W;

		for (genvar i = 0; i < N; i++) begin : g_lane
			// lane i counted from the top
			localparam int HI = spu_data_pkg::QUAD_WIDTH - 1 - i * W;

			logic signed [W:0] a_ext;
			logic signed [W:0] b_ext;
			logic signed [W:0] raw;

			// one guard bit above the lane
			assign a_ext = {a[HI], a[HI -: W]};
			assign b_ext = {b[HI], b[HI -: W]};

			// subtract-from takes ra away from b
			assign raw = (op == spu_isa_pkg::OP_SUBF) ? b_ext - a_ext : a_ext + b_ext;

			// guard and sign bits disagree on overflow
			// clamp toward the guard's sign
			assign size_sum[s][HI -: W] = (raw[W] == raw[W-1]) ? raw[W-1:0] :
				{raw[W], {(W-1){~raw[W]}}};
		end
	end

	assign sum = (size == spu_isa_pkg::SZ_WORD) ? size_sum[1] : size_sum[0];

endmodule

// File: verilog/fx_compare.sv
`timescale 1ns/1ps

module fx_compare (
	input  spu_isa_pkg::fx_op_e     op,
	input  spu_isa_pkg::lane_size_e size,
	input  spu_data_pkg::quad_t     a,
	input  spu_data_pkg::quad_t     b,
	output spu_data_pkg::quad_t     mask
);

	// index 0 halfword lanes, index 1 word lanes
	logic [1:0][spu_data_pkg::QUAD_WIDTH-1:0] size_mask;

	for (genvar s = 0; s < 2; s++) begin : g_size
		localparam int W = (s == 0) ? spu_data_pkg::HALF_WIDTH : spu_data_pkg::WORD_WIDTH;
		localparam int N = spu_data_pkg::QUAD_WIDTH / W;

		for (genvar i = 0; i < N; i++) begin : g_lane
			localparam int HI = spu_data_pkg::QUAD_WIDTH - 1 - i * W;

			logic [W-1:0] av;
			logic [W-1:0] bv;
			logic hit;

			assign av = a[HI -: W];
			assign bv = b[HI -: W];

			// ra against b, signed or logical
			always_comb begin
				case (op)
					spu_isa_pkg::OP_CEQ: hit = (av == bv);
					spu_isa_pkg::OP_CGT: hit = ($signed(av) > $signed(bv));
					default: hit = (av > bv);
				endcase
			end

			// spread the flag over the lane
			assign size_mask[s][HI -: W] = {W{hit}};
		end
	end

	assign mask = (size == spu_isa_pkg::SZ_WORD) ? size_mask[1] : size_mask[0];

endmodule

// File: verilog/fx_simple_unit.sv
`timescale 1ns/1ps

module fx_simple_unit (
	input  logic                    clk,
	input  logic                    reset,
	input  spu_data_pkg::fx_issue_t issue,
	input  logic                    branch_taken,
	output spu_data_pkg::fx_wb_t    wb
);

	spu_data_pkg::fx_decoded_t dec;
	spu_data_pkg::quad_t arith_res;
	spu_data_pkg::quad_t cmp_res;
	spu_data_pkg::quad_t result;
	spu_data_pkg::fx_wb_t wb_next;
	logic squash;
	logic write;

	fx_decode fx_decode_inst (
		.format(issue.format),
		.op(issue.op),
		.imm(issue.imm),
		.rb(issue.rb),
		.dec(dec)
	);

	fx_arith fx_arith_inst (
		.op(dec.op),
		.size(dec.size),
		.a(issue.ra),
		.b(dec.b),
		.sum(arith_res)
	);

	fx_compare fx_compare_inst (
		.op(dec.op),
		.size(dec.size),
		.a(issue.ra),
		.b(dec.b),
		.mask(cmp_res)
	);

	// result mux
	always_comb begin
		case (dec.op)
			spu_isa_pkg::OP_ADD, spu_isa_pkg::OP_SUBF: result = arith_res;
			spu_isa_pkg::OP_AND: result = issue.ra & dec.b;
			spu_isa_pkg::OP_OR: result = issue.ra | dec.b;
			spu_isa_pkg::OP_XOR: result = issue.ra ^ dec.b;
			spu_isa_pkg::OP_NAND: result = ~(issue.ra & dec.b);
			spu_isa_pkg::OP_CEQ, spu_isa_pkg::OP_CGT, spu_isa_pkg::OP_CLGT: result = cmp_res;
			// loads already formed by decode
			spu_isa_pkg::OP_ILH, spu_isa_pkg::OP_ILHU: result = dec.b;
			// keep the old upper halves
			spu_isa_pkg::OP_IOHL: result = issue.rt_st | dec.b;
			default: result = '0;
		endcase
	end

	// nop, unknown opcode or taken branch kills the slot
	assign squash = (dec.op == spu_isa_pkg::OP_NOP) || branch_taken;
	assign write = issue.reg_write && !squash;

	always_comb begin
		wb_next.result = squash ? '0 : result;
		// target address only travels with a write
		wb_next.rt_addr = write ? issue.rt_addr : '0;
		wb_next.reg_write = write;
	end

	// single writeback stage
	always_ff @(posedge clk) begin
		if (reset) begin
			wb <= '0;
		end else begin
			wb <= wb_next;
		end
	end

	// taken branch must suppress the write one cycle later
	a_branch_no_write: assert property (@(posedge clk) disable iff (reset)
		branch_taken |=> !wb.reg_write)
		else $error("fx_simple_unit: write after taken branch");

	// idle writeback slots carry address 0
	a_idle_addr_zero: assert property (@(posedge clk) disable iff (reset)
		!wb.reg_write |-> (wb.rt_addr == '0))
		else $error("fx_simple_unit: nonzero address without write");

endmodule

// File: include/fx_tb_tasks.svh
`ifndef FX_TB_TASKS_SVH
`define FX_TB_TASKS_SVH

// four random words per quadword
function automatic spu_data_pkg::quad_t rand_quad();
	return {$random(seed), $random(seed), $random(seed), $random(seed)};
endfunction

// random registers and target with the write enabled
function automatic spu_data_pkg::fx_issue_t make_issue(spu_isa_pkg::fmt_e format,
		spu_isa_pkg::op_field_t op, spu_isa_pkg::imm_t imm);
	spu_data_pkg::fx_issue_t ins;
	ins.format = format;
	ins.op = op;
	ins.rt_addr = 7'($random(seed));
	ins.ra = rand_quad();
	ins.rb = rand_quad();
	ins.rt_st = rand_quad();
	ins.imm = imm;
	ins.reg_write = 1'b1;
	return ins;
endfunction

// second operand as the unit should build it
// w is the lane width the immediate repeats at
function automatic spu_data_pkg::quad_t operand_b(spu_data_pkg::fx_issue_t ins,
		spu_isa_pkg::fx_op_e kind, int w);
	logic [31:0] pat;
	spu_data_pkg::quad_t b;
	b = ins.rb;
	pat = {16'h0000, ins.imm[15:0]};
	if (ins.format == spu_isa_pkg::FMT_RI10)
		pat = {{22{ins.imm[9]}}, ins.imm[9:0]};
	else if (kind == spu_isa_pkg::OP_ILHU)
		pat = {ins.imm[15:0], 16'h0000};
	if (ins.format != spu_isa_pkg::FMT_RR) begin
		// each pass pushes one lane in from the bottom
		// so lane 0 ends on top
		for (int i = 0; i < 128 / w; i++)
			b = (b << w) | spu_data_pkg::quad_t'(pat & {{16{w == 32}}, 16'hffff});
	end
	return b;
endfunction

// writeback the unit owes for one issue slot
function automatic spu_data_pkg::fx_wb_t expected_wb(spu_data_pkg::fx_issue_t ins,
		spu_isa_pkg::fx_op_e kind, spu_isa_pkg::lane_size_e sz, logic bt);
	spu_data_pkg::fx_wb_t want;
	spu_data_pkg::quad_t b;
	spu_data_pkg::quad_t res;
	logic [31:0] m;
	logic [31:0] ua;
	logic [31:0] ub;
	longint sa;
	longint sb;
	longint r;
	longint lim;
	int w;
	w = (sz == spu_isa_pkg::SZ_WORD) ? 32 : 16;
	m = {{16{w == 32}}, 16'hffff};
	lim = longint'(1) <<< (w - 1);
	b = operand_b(ins, kind, w);
	res = '0;
	for (int i = 0; i < 128 / w; i++) begin
		ua = 32'(ins.ra >> (128 - (i + 1) * w)) & m;
		ub = 32'(b >> (128 - (i + 1) * w)) & m;
		// two's complement value of the lane
		sa = (longint'(ua) >= lim) ? longint'(ua) - 2 * lim : longint'(ua);
		sb = (longint'(ub) >= lim) ? longint'(ub) - 2 * lim : longint'(ub);
		case (kind)
			spu_isa_pkg::OP_ADD: r = sa + sb;
			spu_isa_pkg::OP_SUBF: r = sb - sa;
			spu_isa_pkg::OP_CEQ: r = (ua == ub) ? -1 : 0;
			spu_isa_pkg::OP_CGT: r = (sa > sb) ? -1 : 0;
			spu_isa_pkg::OP_CLGT: r = (ua > ub) ? -1 : 0;
			default: r = 0;
		endcase
		// clamp into the signed lane range
		if (r > lim - 1)
			r = lim - 1;
		else if (r < -lim)
			r = -lim;
		res = (res << w) | spu_data_pkg::quad_t'(32'(r) & m);
	end
	case (kind)
		spu_isa_pkg::OP_AND: res = ins.ra & b;
		spu_isa_pkg::OP_OR: res = ins.ra | b;
		spu_isa_pkg::OP_XOR: res = ins.ra ^ b;
		spu_isa_pkg::OP_NAND: res = ~(ins.ra & b);
		spu_isa_pkg::OP_ILH, spu_isa_pkg::OP_ILHU: res = b;
		spu_isa_pkg::OP_IOHL: res = ins.rt_st | b;
		default: ;
	endcase
	// nothing reaches the register file after a nop or taken branch
	want.result = (kind == spu_isa_pkg::OP_NOP || bt) ? '0 : res;
	want.reg_write = ins.reg_write && kind != spu_isa_pkg::OP_NOP && !bt;
	want.rt_addr = want.reg_write ? ins.rt_addr : '0;
	return want;
endfunction

task automatic check_result(spu_data_pkg::quad_t got, spu_data_pkg::quad_t want);
	if (got !== want) begin
		$display("FAIL time=%0t wb.result got=%h expected=%h", $time, got, want);
		$display("STATUS: FAIL");
		$fatal(1, "writeback result mismatch");
	end
endtask

task automatic check_target(spu_data_pkg::reg_addr_t got_addr, logic got_write,
		spu_data_pkg::reg_addr_t want_addr, logic want_write);
	if (got_write !== want_write) begin
		$display("FAIL time=%0t wb.reg_write got=%b expected=%b", $time, got_write,
			want_write);
		$display("STATUS: FAIL");
		$fatal(1, "writeback write flag mismatch");
	end else if (got_addr !== want_addr) begin
		$display("FAIL time=%0t wb.rt_addr got=%h expected=%h", $time, got_addr, want_addr);
		$display("STATUS: FAIL");
		$fatal(1, "writeback address mismatch");
	end
endtask

// drive one slot and check the slot issued one edge earlier
task automatic step(spu_data_pkg::fx_issue_t ins, spu_isa_pkg::fx_op_e kind,
		spu_isa_pkg::lane_size_e sz, logic bt);
	@(posedge clk);
	issue <= ins;
	branch_taken <= bt;
	// wb settled since the rising edge
	@(negedge clk);
	check_result(wb.result, pending.result);
	check_target(wb.rt_addr, wb.reg_write, pending.rt_addr, pending.reg_write);
	pending = expected_wb(ins, kind, sz, bt);
endtask

`endif

// File: bench/fx_simple_unit_tb.sv
`timescale 1ns/1ps

module fx_simple_unit_tb;

	// tests need about 150 cycles
	localparam int MAX_CYCLES = 2000;

	logic clk = 1'b0;
	logic reset;
	logic branch_taken;
	spu_data_pkg::fx_issue_t issue;
	spu_data_pkg::fx_wb_t wb;
	// expected writeback of the slot in flight
	spu_data_pkg::fx_wb_t pending;
	integer seed = 62703;
	int cycles = 0;

	fx_simple_unit fx_simple_unit_inst (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.branch_taken(branch_taken),
		.wb(wb)
	);

	`include "fx_tb_tasks.svh"

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, tests still running after %0d cycles", cycles);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	// rr add and subtract-from on random lanes then lanes pushed past the limits
	task automatic arith_saturate();
		spu_isa_pkg::op_field_t opc [4];
		spu_data_pkg::fx_issue_t ins;
		spu_data_pkg::quad_t limits;
		spu_isa_pkg::fx_op_e kind;
		logic half;
		opc = '{spu_isa_pkg::OPC_AH, spu_isa_pkg::OPC_A, spu_isa_pkg::OPC_SFH,
			spu_isa_pkg::OPC_SF};
		for (int n = 0; n < 20; n++) begin
			kind = (n % 4 < 2) ? spu_isa_pkg::OP_ADD : spu_isa_pkg::OP_SUBF;
			half = (n % 2 == 0);
			ins = make_issue(spu_isa_pkg::FMT_RR, opc[n % 4], '0);
			if (n >= 16) begin
				limits = half ? {4{16'h7fff, 16'h8000}} : {2{32'h7fff_ffff, 32'h8000_0000}};
				// max plus one and min minus one in both directions
				ins.ra = (kind == spu_isa_pkg::OP_ADD) ? limits :
					(half ? {4{16'hffff, 16'h0001}} : {2{32'hffff_fff0, 32'h0000_0010}});
				ins.rb = (kind == spu_isa_pkg::OP_SUBF) ? limits :
					(half ? {4{16'h0001, 16'hffff}} : {2{32'h0000_0010, 32'hffff_fff0}});
			end
			step(ins, kind, half ? spu_isa_pkg::SZ_HALF : spu_isa_pkg::SZ_WORD, 1'b0);
		end
	endtask

	// logical ops and the three compares before and after planting equal lanes
	task automatic logic_compare_ops();
		spu_isa_pkg::op_field_t opc [10];
		spu_isa_pkg::fx_op_e kind [10];
		spu_data_pkg::fx_issue_t ins;
		int k;
		opc = '{spu_isa_pkg::OPC_AND, spu_isa_pkg::OPC_OR, spu_isa_pkg::OPC_XOR,
			spu_isa_pkg::OPC_NAND, spu_isa_pkg::OPC_CEQH, spu_isa_pkg::OPC_CEQ,
			spu_isa_pkg::OPC_CGTH, spu_isa_pkg::OPC_CGT, spu_isa_pkg::OPC_CLGTH,
			spu_isa_pkg::OPC_CLGT};
		kind = '{spu_isa_pkg::OP_AND, spu_isa_pkg::OP_OR, spu_isa_pkg::OP_XOR,
			spu_isa_pkg::OP_NAND, spu_isa_pkg::OP_CEQ, spu_isa_pkg::OP_CEQ,
			spu_isa_pkg::OP_CGT, spu_isa_pkg::OP_CGT, spu_isa_pkg::OP_CLGT,
			spu_isa_pkg::OP_CLGT};
		for (int n = 0; n < 30; n++) begin
			k = n % 10;
			ins = make_issue(spu_isa_pkg::FMT_RR, opc[k], '0);
			if (n >= 10 && n < 20)
				ins.rb[127:64] = ins.ra[127:64];
			else if (n >= 20)
				ins.rb[63:0] = ins.ra[63:0];
			step(ins, kind[k], (k >= 4 && k % 2 == 0) ? spu_isa_pkg::SZ_HALF :
				spu_isa_pkg::SZ_WORD, 1'b0);
		end
	endtask

	// ri10 forms with positive, negative and most negative imm10
	task automatic ri10_forms();
		spu_isa_pkg::op_field_t opc [16];
		spu_isa_pkg::fx_op_e kind [8];
		logic [9:0] imm10 [3];
		spu_data_pkg::fx_issue_t ins;
		spu_data_pkg::quad_t b;
		spu_isa_pkg::lane_size_e sz;
		opc = '{spu_isa_pkg::OPC_AHI, spu_isa_pkg::OPC_AI, spu_isa_pkg::OPC_SFHI,
			spu_isa_pkg::OPC_SFI, spu_isa_pkg::OPC_ANDHI, spu_isa_pkg::OPC_ANDI,
			spu_isa_pkg::OPC_ORHI, spu_isa_pkg::OPC_ORI, spu_isa_pkg::OPC_XORHI,
			spu_isa_pkg::OPC_XORI, spu_isa_pkg::OPC_CEQHI, spu_isa_pkg::OPC_CEQI,
			spu_isa_pkg::OPC_CGTHI, spu_isa_pkg::OPC_CGTI, spu_isa_pkg::OPC_CLGTHI,
			spu_isa_pkg::OPC_CLGTI};
		kind = '{spu_isa_pkg::OP_ADD, spu_isa_pkg::OP_SUBF, spu_isa_pkg::OP_AND,
			spu_isa_pkg::OP_OR, spu_isa_pkg::OP_XOR, spu_isa_pkg::OP_CEQ,
			spu_isa_pkg::OP_CGT, spu_isa_pkg::OP_CLGT};
		imm10 = '{10'h07b, 10'h385, 10'h200};
		for (int n = 0; n < 48; n++) begin
			sz = (n % 2 == 0) ? spu_isa_pkg::SZ_HALF : spu_isa_pkg::SZ_WORD;
			// noise above imm10 must not leak in
			ins = make_issue(spu_isa_pkg::FMT_RI10, opc[n % 16],
				{8'($random(seed)), imm10[n / 16]});
			// top lanes of ra equal the immediate in the negative rounds
			if (n >= 16) begin
				b = operand_b(ins, kind[(n % 16) / 2], (sz == spu_isa_pkg::SZ_WORD) ? 32 : 16);
				ins.ra[127:64] = b[127:64];
			end
			step(ins, kind[(n % 16) / 2], sz, 1'b0);
		end
	endtask

	task automatic ri16_loads();
		for (int n = 0; n < 3; n++) begin
			step(make_issue(spu_isa_pkg::FMT_RI16, spu_isa_pkg::OPC_ILH, 18'($random(seed))),
				spu_isa_pkg::OP_ILH, spu_isa_pkg::SZ_HALF, 1'b0);
			step(make_issue(spu_isa_pkg::FMT_RI16, spu_isa_pkg::OPC_ILHU, 18'($random(seed))),
				spu_isa_pkg::OP_ILHU, spu_isa_pkg::SZ_WORD, 1'b0);
			// random rt_st keeps its upper halves
			step(make_issue(spu_isa_pkg::FMT_RI16, spu_isa_pkg::OPC_IOHL, 18'($random(seed))),
				spu_isa_pkg::OP_IOHL, spu_isa_pkg::SZ_WORD, 1'b0);
		end
	endtask

	// squashed slots between live ones with no gaps
	task automatic squash_interleave();
		spu_data_pkg::fx_issue_t ins;
		step(make_issue(spu_isa_pkg::FMT_RR, spu_isa_pkg::OPC_AH, '0),
			spu_isa_pkg::OP_ADD, spu_isa_pkg::SZ_HALF, 1'b0);
		step(make_issue(spu_isa_pkg::FMT_RR, '0, '0),
			spu_isa_pkg::OP_NOP, spu_isa_pkg::SZ_HALF, 1'b0);
		step(make_issue(spu_isa_pkg::FMT_RR, 11'h7ff, '0),
			spu_isa_pkg::OP_NOP, spu_isa_pkg::SZ_HALF, 1'b0);
		// ri10 opcode under the rr format
		step(make_issue(spu_isa_pkg::FMT_RR, spu_isa_pkg::OPC_AI, '0),
			spu_isa_pkg::OP_NOP, spu_isa_pkg::SZ_HALF, 1'b0);
		step(make_issue(spu_isa_pkg::FMT_RI10, spu_isa_pkg::OPC_AI, 18'h00005),
			spu_isa_pkg::OP_ADD, spu_isa_pkg::SZ_WORD, 1'b1);
		step(make_issue(spu_isa_pkg::FMT_RR, spu_isa_pkg::OPC_CGT, '0),
			spu_isa_pkg::OP_CGT, spu_isa_pkg::SZ_WORD, 1'b1);
		step(make_issue(spu_isa_pkg::fmt_e'(3'd7), spu_isa_pkg::OPC_ILH, '0),
			spu_isa_pkg::OP_NOP, spu_isa_pkg::SZ_HALF, 1'b0);
		// result still formed but no write means address 0
		ins = make_issue(spu_isa_pkg::FMT_RR, spu_isa_pkg::OPC_XOR, '0);
		ins.reg_write = 1'b0;
		step(ins, spu_isa_pkg::OP_XOR, spu_isa_pkg::SZ_WORD, 1'b0);
		step(make_issue(spu_isa_pkg::FMT_RR, spu_isa_pkg::OPC_SF, '0),
			spu_isa_pkg::OP_SUBF, spu_isa_pkg::SZ_WORD, 1'b0);
	endtask

	initial begin
		spu_data_pkg::fx_issue_t held;
		reset = 1'b1;
		// a live write sits on the issue port for the whole reset
		held = make_issue(spu_isa_pkg::FMT_RR, spu_isa_pkg::OPC_OR, '0);
		issue = held;
		branch_taken = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		// reset kept the held write out of wb
		@(negedge clk);
		check_result(wb.result, '0);
		check_target(wb.rt_addr, wb.reg_write, '0, 1'b0);
		// first edge out of reset takes the held instruction
		pending = expected_wb(held, spu_isa_pkg::OP_OR, spu_isa_pkg::SZ_WORD, 1'b0);
		arith_saturate();
		logic_compare_ops();
		ri10_forms();
		ri16_loads();
		squash_interleave();
		// flush the last slot
		step('0, spu_isa_pkg::OP_NOP, spu_isa_pkg::SZ_HALF, 1'b0);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: list.f
+incdir+include
verilog/spu_isa_pkg.sv
verilog/spu_data_pkg.sv
verilog/fx_decode.sv
verilog/fx_arith.sv
verilog/fx_compare.sv
verilog/fx_simple_unit.sv
bench/fx_simple_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fx_simple_unit_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
